// File: Makefile
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= r5p_core_tb
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard design/*.sv design/*.svh sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+design
design/r5p_pkg.sv
design/r5p_dec.sv
design/r5p_gpr.sv
design/r5p_alu.sv
design/r5p_lsu.sv
design/r5p_core.sv
sim/r5p_core_tb.sv

// File: design/r5p_alu.sv
// arithmetic/logic unit with operand select
// adder sum side output and branch condition compare

`timescale 1ns/10ps
`default_nettype none
`include "r5p_config.svh"

module r5p_alu import r5p_pkg::*; (
  input  alu_op_t              op,
  input  alu_a_t               a_sel,
  input  alu_b_t               b_sel,
  input  bru_t                 bru,
  input  logic [`R5P_XLEN-1:0] pc,
  input  logic [`R5P_XLEN-1:0] rs1,
  input  logic [`R5P_XLEN-1:0] rs2,
  input  logic [`R5P_XLEN-1:0] imm,
  output logic [`R5P_XLEN-1:0] res,
  output logic [`R5P_XLEN-1:0] sum,  // jump target, load/store address
  output logic                 tkn   // branch taken
);

  localparam int SW = $clog2(`R5P_XLEN);  // shift amount width

  logic [`R5P_XLEN-1:0] opa;
  logic [`R5P_XLEN-1:0] opb;
  logic [SW-1:0]        sha;
  logic                 eq;   // rs1 == rs2
  logic                 lts;  // signed less than
  logic                 ltu;  // unsigned less than

  always_comb begin
    case (a_sel)
      A_PC:    opa = pc;
      A_ZERO:  opa = '0;
      default: opa = rs1;
    endcase
  end

  assign opb = (b_sel == B_IMM) ? imm : rs2;
  assign sum = opa + opb;
  assign sha = opb[SW-1:0];

  always_comb begin
    case (op)
      SUB:     res = opa - opb;
      SLL:     res = opa << sha;
      SLT:     res = `R5P_XLEN'($signed(opa) < $signed(opb));
      SLTU:    res = `R5P_XLEN'(opa < opb);
      XOR:     res = opa ^ opb;
      SRL:     res = opa >> sha;
      SRA:     res = $unsigned($signed(opa) >>> sha);  // arithmetic
      OR:      res = opa | opb;
      AND:     res = opa & opb;
      default: res = sum;  // add
    endcase
  end

  // branch compare on register values, own comparators
  assign eq  = (rs1 == rs2);
  assign lts = ($signed(rs1) < $signed(rs2));
  assign ltu = (rs1 < rs2);

  always_comb begin
    case (bru)
      BEQ:     tkn = eq;
      BNE:     tkn = ~eq;
      BLT:     tkn = lts;
      BGE:     tkn = ~lts;
      BLTU:    tkn = ltu;
      BGEU:    tkn = ~ltu;
      default: tkn = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/r5p_config.svh
// core configuration defines
// register width, reset vector, register count

`ifndef R5P_CONFIG_SVH
`define R5P_CONFIG_SVH

// register and data bus width, one word
`define R5P_XLEN 32

// reset vector, first fetch address
`define R5P_PC0 32'h0000_0000

// number of general purpose registers, x0 included
`define R5P_NREG 32

`endif

// File: design/r5p_core.sv
// RV32I core top level
// fetch, program counter, stall, write-back select and the datapath blocks

`timescale 1ns/10ps
`default_nettype none
`include "r5p_config.svh"

module r5p_core import r5p_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  // program bus
  output logic                 if_vld,
  output logic [`R5P_XLEN-1:0] if_adr,
  input  logic [31:0]          if_rdt,
  input  logic                 if_rdy,
  // data bus
  output logic                 ls_vld,
  output logic                 ls_wen,
  output logic [`R5P_XLEN-1:0] ls_adr,
  output logic [`R5P_XLEN-1:0] ls_wdt,
  input  logic [`R5P_XLEN-1:0] ls_rdt,
  input  logic                 ls_rdy
);

  // fetch and pc
  logic                 if_arm;  // first cycle out of reset
  logic                 if_run;
  logic [`R5P_XLEN-1:0] if_pc;
  logic [`R5P_XLEN-1:0] if_pcn;  // next pc, also fetch address
  logic [`R5P_XLEN-1:0] if_pci;  // pc + 4
  logic [`R5P_XLEN-1:0] if_pcb;  // pc + imm
  logic                 if_tkn;
  logic                 stall;   // data bus holds the instruction
  logic                 ex_ret;  // instruction retires
  // decode
  logic                 id_vld;
  opc_t                 id_opc;
  alu_op_t              id_alu_op;
  alu_a_t               id_alu_a;
  alu_b_t               id_alu_b;
  bru_t                 id_bru;
  pc_t                  id_pc;
  wb_t                  id_wb;
  logic                 id_ld;
  logic                 id_st;
  logic [4:0]           id_rs1;
  logic [4:0]           id_rs2;
  logic [4:0]           id_rd;
  logic [`R5P_XLEN-1:0] id_imm;
  // datapath
  logic [`R5P_XLEN-1:0] gpr_rs1;
  logic [`R5P_XLEN-1:0] gpr_rs2;
  logic [`R5P_XLEN-1:0] alu_res;
  logic [`R5P_XLEN-1:0] alu_sum;
  logic                 alu_tkn;
  logic [`R5P_XLEN-1:0] lsu_rdt;
  logic                 lsu_dly;
  logic                 wbu_wen;
  logic [`R5P_XLEN-1:0] wbu_dat;

  //////////////////////////////////////////////////////////////////////
  // fetch
  //////////////////////////////////////////////////////////////////////

  // fetch starts on the second edge after reset
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      if_arm <= 1'b0;
      if_run <= 1'b0;
    end else begin
      if_arm <= 1'b1;
      if_run <= if_arm;
    end
  end

  // store waiting for ready, or any load request
  assign stall  = ls_vld & (~ls_rdy | ~ls_wen);
  assign if_vld = if_run & ~stall;  // if_rdt must stay put while stalled
  assign if_adr = if_pcn;
  assign ex_ret = id_vld & ~stall;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      id_vld <= 1'b0;
    end else begin
      id_vld <= (if_vld & if_rdy) | (id_vld & stall);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // program counter
  //////////////////////////////////////////////////////////////////////

  assign if_pci = if_pc + `R5P_XLEN'(4);
  assign if_pcb = if_pc + id_imm;  // branch and jal target
  assign if_tkn = alu_tkn & (id_opc == OPC_BRANCH);

  always_comb begin
    if (id_vld) begin
      case (id_pc)
        PC_BRN:  if_pcn = if_tkn ? if_pcb : if_pci;
        PC_JAL:  if_pcn = if_pcb;
        PC_JMP:  if_pcn = {alu_sum[`R5P_XLEN-1:1], 1'b0};  // jalr clears bit 0
        default: if_pcn = if_pci;
      endcase
    end else begin
      if_pcn = if_pc;  // refetch after a rejected fetch
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      if_pc <= `R5P_PC0;
    end else if (ex_ret) begin
      if_pc <= if_pcn;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // write-back
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_wb)
      WB_ALU:  wbu_dat = alu_res;
      WB_PCI:  wbu_dat = if_pci;   // link
      WB_LSU:  wbu_dat = lsu_rdt;
      default: wbu_dat = '0;
    endcase
  end

  // loads write on the delayed strobe
  assign wbu_wen = (id_wb == WB_LSU) ? lsu_dly : ex_ret & (id_wb != WB_NONE);

  //////////////////////////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////////////////////////

  r5p_dec u_dec (
    .inst   (if_rdt),
    .opc    (id_opc),
    .alu_op (id_alu_op),
    .alu_a  (id_alu_a),
    .alu_b  (id_alu_b),
    .bru    (id_bru),
    .pc_sel (id_pc),
    .wb_sel (id_wb),
    .ld     (id_ld),
    .st     (id_st),
    .rs1    (id_rs1),
    .rs2    (id_rs2),
    .rd     (id_rd),
    .imm    (id_imm)
  );

  r5p_gpr u_gpr (
    .clk     (clk),
    .rst     (rst),
    .rs1_adr (id_rs1),
    .rs2_adr (id_rs2),
    .rs1_dat (gpr_rs1),
    .rs2_dat (gpr_rs2),
    .wen     (wbu_wen),
    .wr_adr  (id_rd),
    .wr_dat  (wbu_dat)
  );

  r5p_alu u_alu (
    .op    (id_alu_op),
    .a_sel (id_alu_a),
    .b_sel (id_alu_b),
    .bru   (id_bru),
    .pc    (if_pc),
    .rs1   (gpr_rs1),
    .rs2   (gpr_rs2),
    .imm   (id_imm),
    .res   (alu_res),
    .sum   (alu_sum),
    .tkn   (alu_tkn)
  );

  r5p_lsu u_lsu (
    .clk    (clk),
    .rst    (rst),
    .ld     (id_ld),
    .st     (id_st),
    .ena    (id_vld),
    .adr    (alu_sum),  // rs1 + imm
    .wdt    (gpr_rs2),
    .rdt    (lsu_rdt),
    .dly    (lsu_dly),
    .ls_vld (ls_vld),
    .ls_wen (ls_wen),
    .ls_adr (ls_adr),
    .ls_wdt (ls_wdt),
    .ls_rdt (ls_rdt),
    .ls_rdy (ls_rdy)
  );

endmodule

`default_nettype wire

// File: design/r5p_dec.sv
// instruction decoder
// control fields and sign-extended immediate from a 32-bit instruction

`timescale 1ns/10ps
`default_nettype none
`include "r5p_config.svh"

module r5p_dec import r5p_pkg::*; (
  input  logic [31:0]          inst,
  output opc_t                 opc,
  output alu_op_t              alu_op,
  output alu_a_t               alu_a,
  output alu_b_t               alu_b,
  output bru_t                 bru,
  output pc_t                  pc_sel,
  output wb_t                  wb_sel,
  output logic                 ld,
  output logic                 st,
  output logic [4:0]           rs1,
  output logic [4:0]           rs2,
  output logic [4:0]           rd,
  output logic [`R5P_XLEN-1:0] imm
);

  logic [2:0]           f3;     // funct3
  logic [6:0]           f7;     // funct7
  logic                 shf_ok; // legal funct7 for immediate shifts
  logic [`R5P_XLEN-1:0] imm_i;
  logic [`R5P_XLEN-1:0] imm_s;
  logic [`R5P_XLEN-1:0] imm_b;
  logic [`R5P_XLEN-1:0] imm_u;
  logic [`R5P_XLEN-1:0] imm_j;

  // funct3 plus alternate bit to ALU operation
  function automatic alu_op_t alu_dec(input logic [2:0] fn3, input logic alt);
    case (fn3)
      3'b000:  return alt ? SUB : ADD;
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return alt ? SRA : SRL;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  assign opc = opc_t'(inst[6:2]);
  assign f3  = inst[14:12];
  assign f7  = inst[31:25];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];
  assign bru = bru_t'(f3);  // only looked at for branches

  assign shf_ok = (f7 == 7'b000_0000) | ((f3 == 3'b101) & (f7 == 7'b010_0000));

  // immediates per format
  assign imm_i = `R5P_XLEN'($signed(inst[31:20]));
  assign imm_s = `R5P_XLEN'($signed({inst[31:25], inst[11:7]}));
  assign imm_b = `R5P_XLEN'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
  assign imm_u = `R5P_XLEN'($signed({inst[31:12], 12'h000}));
  assign imm_j = `R5P_XLEN'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));

  always_comb begin
    // default is increment only, nothing written
    alu_op = ADD;
    alu_a  = A_RS1;
    alu_b  = B_IMM;
    pc_sel = PC_PCI;
    wb_sel = WB_NONE;
    ld     = 1'b0;
    st     = 1'b0;
    imm    = imm_i;
    if (inst[1:0] == 2'b11) begin  // 32-bit encodings only
      case (opc)
        OPC_OP: begin
          if (shf_ok || f7 == 7'b000_0000 || (f3 == 3'b000 && f7 == 7'b010_0000)) begin
            alu_op = alu_dec(f3, f7[5]);
            alu_b  = B_RS2;
            wb_sel = WB_ALU;
          end
        end
        OPC_OP_IMM: begin
          if ((f3 != 3'b001 && f3 != 3'b101) || shf_ok) begin
            alu_op = alu_dec(f3, (f3 == 3'b101) & f7[5]);  // no subi
            wb_sel = WB_ALU;
          end
        end
        OPC_LUI: begin
          alu_a  = A_ZERO;  // 0 + imm
          imm    = imm_u;
          wb_sel = WB_ALU;
        end
        OPC_AUIPC: begin
          alu_a  = A_PC;
          imm    = imm_u;
          wb_sel = WB_ALU;
        end
        OPC_BRANCH: begin
          if (f3 != 3'b010 && f3 != 3'b011) begin
            pc_sel = PC_BRN;
            imm    = imm_b;
          end
        end
        OPC_JAL: begin
          pc_sel = PC_JAL;
          imm    = imm_j;
          wb_sel = WB_PCI;
        end
        OPC_JALR: begin
          if (f3 == 3'b000) begin
            pc_sel = PC_JMP;  // target is rs1 + imm from ALU
            wb_sel = WB_PCI;
          end
        end
        OPC_LOAD: begin
          if (f3 == 3'b010) begin  // lw only
            ld     = 1'b1;
            wb_sel = WB_LSU;
          end
        end
        OPC_STORE: begin
          if (f3 == 3'b010) begin  // sw only
            st  = 1'b1;
            imm = imm_s;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/r5p_gpr.sv
// general purpose register file
// two asynchronous read ports, one clocked write port, x0 fixed at zero

`timescale 1ns/10ps
`default_nettype none
`include "r5p_config.svh"

module r5p_gpr (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [4:0]           rs1_adr,
  input  logic [4:0]           rs2_adr,
  output logic [`R5P_XLEN-1:0] rs1_dat,
  output logic [`R5P_XLEN-1:0] rs2_dat,
  input  logic                 wen,
  input  logic [4:0]           wr_adr,
  input  logic [`R5P_XLEN-1:0] wr_dat
);

  // no storage behind x0
  logic [`R5P_XLEN-1:0] gpr [1:`R5P_NREG-1];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 1; i < `R5P_NREG; i++) begin
        gpr[i] <= '0;
      end
    end else if (wen && wr_adr != 5'd0) begin  // writes to x0 dropped
      gpr[wr_adr] <= wr_dat;
    end
  end

  // combinational reads
  assign rs1_dat = (rs1_adr == 5'd0) ? '0 : gpr[rs1_adr];
  assign rs2_dat = (rs2_adr == 5'd0) ? '0 : gpr[rs2_adr];

endmodule

`default_nettype wire

// File: design/r5p_lsu.sv
// load/store unit
// data bus request, one cycle load write-back delay, load data pass-through

`timescale 1ns/10ps
`default_nettype none
`include "r5p_config.svh"

module r5p_lsu (
  input  logic                 clk,
  input  logic                 rst,
  // control
  input  logic                 ld,
  input  logic                 st,
  input  logic                 ena,     // instruction valid
  // core side
  input  logic [`R5P_XLEN-1:0] adr,
  input  logic [`R5P_XLEN-1:0] wdt,
  output logic [`R5P_XLEN-1:0] rdt,
  output logic                 dly,     // load write-back cycle
  // data bus
  output logic                 ls_vld,
  output logic                 ls_wen,
  output logic [`R5P_XLEN-1:0] ls_adr,
  output logic [`R5P_XLEN-1:0] ls_wdt,
  input  logic [`R5P_XLEN-1:0] ls_rdt,
  input  logic                 ls_rdy
);

  logic ld_xfr;  // load request accepted this cycle

  //////////////////////////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////////////////////////

  // quiet during write-back, else the load goes out twice
  assign ls_vld = ena & (ld | st) & ~dly;
  assign ls_wen = st;
  assign ls_adr = {adr[`R5P_XLEN-1:2], 2'b00};  // word aligned
  assign ls_wdt = wdt;

  //////////////////////////////////////////////////////////////////////
  // load response
  //////////////////////////////////////////////////////////////////////

  assign ld_xfr = ls_vld & ls_rdy & ~ls_wen;

  // read data shows up the cycle after the transfer
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      dly <= 1'b0;
    end else begin
      dly <= ld_xfr;  // single cycle strobe
    end
  end

  assign rdt = dly ? ls_rdt : '0;

endmodule

`default_nettype wire

// File: design/r5p_pkg.sv
// shared types for the core
// opcodes, ALU operations, branch conditions, PC and write-back sources

`default_nettype none

package r5p_pkg;

  //////////////////////////////////////////////////////////////////////
  // instruction encodings
  //////////////////////////////////////////////////////////////////////

  // major opcode, inst[6:2]
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'b00000,
    OPC_OP_IMM = 5'b00100,
    OPC_AUIPC  = 5'b00101,
    OPC_STORE  = 5'b01000,
    OPC_OP     = 5'b01100,
    OPC_LUI    = 5'b01101,
    OPC_BRANCH = 5'b11000,
    OPC_JALR   = 5'b11001,
    OPC_JAL    = 5'b11011
  } opc_t;

  // branch condition, same code as funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } bru_t;

  //////////////////////////////////////////////////////////////////////
  // datapath control
  //////////////////////////////////////////////////////////////////////

  // ALU operation
  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_op_t;

  // ALU operand A
  typedef enum logic [1:0] {
    A_RS1,   // register source 1
    A_PC,    // auipc
    A_ZERO   // lui
  } alu_a_t;

  // ALU operand B
  typedef enum logic {
    B_RS2,
    B_IMM
  } alu_b_t;

  // next PC source
  typedef enum logic [1:0] {
    PC_PCI,  // increment
    PC_BRN,  // conditional branch
    PC_JAL,  // pc relative jump
    PC_JMP   // register jump
  } pc_t;

  // register write-back source
  typedef enum logic [1:0] {
    WB_NONE,
    WB_ALU,
    WB_PCI,  // link address
    WB_LSU
  } wb_t;

endpackage

`default_nettype wire

// File: sim/r5p_core_tb.sv
// testbench for the RV32I core
// bus memory models, instruction encoders, reference ISA model, store checker

`timescale 1ns/10ps
`default_nettype none
`include "r5p_config.svh"

module r5p_core_tb;

  localparam logic [6:0]  OP_IMM  = 7'h13;
  localparam logic [6:0]  OP_LOAD = 7'h03;
  localparam logic [6:0]  OP_JALR = 7'h67;
  localparam logic [6:0]  OP_LUI  = 7'h37;
  localparam logic [6:0]  OP_AUI  = 7'h17;
  localparam logic [31:0] END_ADR = 32'h0000_0ffc;  // store here ends the run

  logic        clk;
  logic        rst;
  logic        if_vld, if_rdy, ls_vld, ls_wen, ls_rdy;
  logic [31:0] if_adr, if_rdt, ls_adr, ls_wdt, ls_rdt;
  logic [31:0] pmem [1024];
  logic [31:0] dmem [1024];
  logic [31:0] exp_adr [$];  // reference store list
  logic [31:0] exp_dat [$];
  int          pc_n, n_ref, limit, cycles, n_st, err_val, err_other;
  int          br_f3 [6] = '{0, 1, 4, 5, 6, 7};  // branch funct3 codes
  logic        first_if, run_end;

  r5p_core u_r5p_core (
    .clk(clk), .rst(rst),
    .if_vld(if_vld), .if_adr(if_adr), .if_rdt(if_rdt), .if_rdy(if_rdy),
    .ls_vld(ls_vld), .ls_wen(ls_wen), .ls_adr(ls_adr), .ls_wdt(ls_wdt),
    .ls_rdt(ls_rdt), .ls_rdy(ls_rdy)
  );

  always #10 clk = ~clk;  // 20 ns period

  //////////////////////////////////////////////////////////////////////
  // instruction encoders
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_r(input int f7, rs2, rs1, f3, rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input int imm, rs1, f3, rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_s(input int imm, rs2, rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input int imm, rs2, rs1, f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(input int imm, rd, input logic [6:0] op);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_j(input int imm, rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic logic [31:0] fill_word(input int i);
    return (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000;  // depends on the whole index
  endfunction

  task automatic put(input logic [31:0] w);
    pmem[pc_n] = w;
    pc_n++;
  endtask

  // sw rs,0(x31) then bump the store pointer
  task automatic save(input int rs);
    put(enc_s(0, rs, 31));
    put(enc_i(4, 31, 0, 31, OP_IMM));
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // runs the program, fills the expected store list, returns instruction count
  function automatic int ref_run();
    logic [31:0] x [32];
    logic [31:0] m [1024];
    logic [31:0] pc, in, a, b, ii, is, ib, adr;
    logic        tk;
    int          n;
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int i = 0; i < 1024; i++) m[i] = fill_word(i);
    pc = `R5P_PC0;
    n  = 0;
    while (n < 5000) begin
      in = pmem[pc[11:2]];
      n++;
      a  = x[in[19:15]];
      b  = x[in[24:20]];
      ii = {{20{in[31]}}, in[31:20]};
      is = {{20{in[31]}}, in[31:25], in[11:7]};
      ib = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
      case (in[6:0])
        7'h33: x[in[11:7]] = alu_ref(in[14:12], in[30], a, b);
        7'h13: x[in[11:7]] = alu_ref(in[14:12], in[30] & (in[14:12] == 3'd5), a, ii);
        7'h37: x[in[11:7]] = {in[31:12], 12'h000};
        7'h17: x[in[11:7]] = pc + {in[31:12], 12'h000};
        7'h6f: begin
          x[in[11:7]] = pc + 4;
          pc = pc + {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0} - 4;
        end
        7'h67: begin
          x[in[11:7]] = pc + 4;
          pc = ((a + ii) & ~32'd1) - 4;
        end
        7'h63: begin
          case (in[14:12])
            3'd0:    tk = (a == b);
            3'd1:    tk = (a != b);
            3'd4:    tk = ($signed(a) < $signed(b));
            3'd5:    tk = ($signed(a) >= $signed(b));
            3'd6:    tk = (a < b);
            default: tk = (a >= b);
          endcase
          if (tk) pc = pc + ib - 4;
        end
        7'h03: x[in[11:7]] = m[adr_w(a + ii)];
        7'h23: begin
          adr = a + is;
          m[adr_w(adr)] = b;
          exp_adr.push_back(adr);
          exp_dat.push_back(b);
          if (adr == END_ADR) return n;
        end
        default: ;
      endcase
      x[0] = '0;  // x0 stays zero
      pc = pc + 4;
    end
    return n;
  endfunction

  function automatic logic [9:0] adr_w(input logic [31:0] adr);
    return adr[11:2];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // program
  //////////////////////////////////////////////////////////////////////

  task automatic build_program();
    pc_n = 0;
    for (int i = 0; i < 1024; i++) pmem[i] = enc_j(0, 0);  // spin
    put(enc_i(32'h100, 0, 0, 31, OP_IMM));                 // store pointer
    put(enc_i(100, 0, 0, 1, OP_IMM));
    save(1);
    put(enc_i(-7, 0, 0, 2, OP_IMM));
    save(2);
    put(enc_r(0, 2, 1, 0, 3));         // add
    save(3);
    put(enc_r(32, 1, 2, 0, 4));        // sub
    save(4);
    put(enc_r(0, 2, 1, 1, 5));         // sll by 25
    save(5);
    put(enc_i(3, 2, 1, 6, OP_IMM));    // slli
    save(6);
    put(enc_i(4, 2, 5, 7, OP_IMM));    // srli
    save(7);
    put(enc_i(32'h402, 2, 5, 8, OP_IMM));  // srai
    save(8);
    put(enc_r(0, 1, 2, 5, 9));         // srl
    save(9);
    put(enc_r(32, 1, 2, 5, 10));       // sra
    save(10);
    put(enc_r(0, 1, 2, 2, 11));        // slt
    save(11);
    put(enc_r(0, 1, 2, 3, 12));        // sltu
    save(12);
    put(enc_i(101, 1, 2, 13, OP_IMM)); // slti
    save(13);
    put(enc_i(5, 2, 3, 14, OP_IMM));   // sltiu
    save(14);
    put(enc_r(0, 2, 1, 4, 15));
    save(15);
    put(enc_r(0, 2, 1, 6, 16));
    save(16);
    put(enc_r(0, 2, 1, 7, 17));
    save(17);
    put(enc_i(32'h5a5, 1, 4, 15, OP_IMM));
    save(15);
    put(enc_i(32'h0f0, 2, 6, 16, OP_IMM));
    save(16);
    put(enc_i(32'h3c3, 2, 7, 17, OP_IMM));
    save(17);
    put(enc_u(32'habcde, 18, OP_LUI));
    save(18);
    put(enc_u(32'h00012, 19, OP_AUI));
    save(19);
    put(enc_i(5, 1, 0, 0, OP_IMM));    // write to x0
    save(0);
    // branch loop, x20 from -3 to 2 against x22 = 1, one counter per condition
    put(enc_i(1, 0, 0, 22, OP_IMM));
    put(enc_i(-3, 0, 0, 20, OP_IMM));
    put(enc_i(3, 0, 0, 21, OP_IMM));
    foreach (br_f3[k]) begin
      put(enc_b(8, 22, 20, br_f3[k]));  // taken lands on the count
      put(enc_j(8, 0));
      put(enc_i(1, 23 + k, 0, 23 + k, OP_IMM));
    end
    put(enc_i(1, 20, 0, 20, OP_IMM));
    put(enc_b(-76, 21, 20, 4));          // blt back to loop start
    for (int r = 20; r <= 28; r++) save(r);
    // jal over two stores that must not happen
    put(enc_j(12, 5));
    put(enc_s(0, 1, 31));
    put(enc_s(0, 1, 31));
    save(5);
    // jalr over two more
    put(enc_u(0, 6, OP_AUI));
    put(enc_i(16, 6, 0, 7, OP_JALR));
    put(enc_s(0, 2, 31));
    put(enc_s(0, 2, 31));
    save(7);
    // store, load back, dependent add
    put(enc_s(0, 3, 31));
    put(enc_i(0, 31, 2, 8, OP_LOAD));
    put(enc_r(0, 1, 8, 0, 9));
    put(enc_i(4, 31, 0, 31, OP_IMM));
    save(9);
    put(enc_i(32'h40, 0, 2, 10, OP_LOAD));  // preset memory word
    save(10);
    put(enc_u(1, 30, OP_LUI));
    put(enc_s(-4, 9, 30));                  // end store
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus models and checker
  //////////////////////////////////////////////////////////////////////

  // program bus, read data the cycle after the transfer
  always @(posedge clk) begin
    logic [31:0] nxt;
    nxt = if_rdt;
    if (!rst && if_vld && if_rdy) begin
      if (first_if) begin
        assert (if_adr == `R5P_PC0) else begin
          $display("CHECK FAILED first fetch address expected %h actual %h", `R5P_PC0, if_adr);
          err_val++;
        end
        first_if = 1'b0;
      end
      nxt = pmem[adr_w(if_adr)];
    end
    #1;
    if_rdt = nxt;
    if_rdy = ($urandom % 4) != 0;  // low about one cycle in four
  end

  // data bus with store compare
  always @(posedge clk) begin
    logic [31:0] rd;
    rd = ls_rdt;
    if (!rst && ls_vld && ls_rdy) begin
      if (ls_wen) begin
        dmem[adr_w(ls_adr)] = ls_wdt;
        if (exp_adr.size() == 0) begin
          $display("store to %h after the expected store list ran out", ls_adr);
          err_other++;
        end else begin
          assert (ls_adr == exp_adr[0]) else begin
            $display("CHECK FAILED store %0d address expected %h actual %h",
                     n_st, exp_adr[0], ls_adr);
            err_val++;
          end
          assert (ls_wdt == exp_dat[0]) else begin
            $display("CHECK FAILED store %0d data expected %h actual %h",
                     n_st, exp_dat[0], ls_wdt);
            err_val++;
          end
          void'(exp_adr.pop_front());
          void'(exp_dat.pop_front());
        end
        n_st++;
        if (ls_adr == END_ADR) run_end = 1'b1;
      end else begin
        rd = dmem[adr_w(ls_adr)];
      end
    end
    #1;
    ls_rdt = rd;
    ls_rdy = ($urandom % 4) != 0;
  end

  // quiet valids through reset, then the cycle counter
  always @(posedge clk) begin
    if (rst || cycles <= 1) begin  // values sampled before the edge
      assert (!if_vld && !ls_vld) else begin
        $display("CHECK FAILED reset valids expected 00 actual %b%b", if_vld, ls_vld);
        err_val++;
      end
    end
    if (!rst) begin
      cycles++;
      if (cycles > limit && !run_end) begin
        $display("timeout after %0d cycles without the end store", cycles);
        err_other++;
        run_end = 1'b1;
      end
    end
  end

  initial begin
    void'($urandom(32'h3c00));
    clk = 1'b0;
    rst = 1'b1;
    if_rdy = 1'b0;
    if_rdt = '0;
    ls_rdy = 1'b0;
    ls_rdt = '0;
    cycles = 0;
    n_st = 0;
    err_val = 0;
    err_other = 0;
    first_if = 1'b1;
    run_end = 1'b0;
    build_program();
    for (int i = 0; i < 1024; i++) dmem[i] = fill_word(i);
    n_ref = ref_run();
    limit = 40 * n_ref;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    wait (run_end);
    #5;
    $display("errors: %0d value, %0d other, %0d stores seen", err_val, err_other, n_st);
    if (err_val == 0 && err_other == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
